// File: game_pkg.sv
package game_pkg;

    // playfield
    localparam int grid_w = 16;
    localparam int grid_h = 16;
    localparam int max_cells = grid_w * grid_h;

    // snake and fruit start state
    localparam int start_len = 4;
    localparam int start_x = 8;       // head cell, body trails left
    localparam int start_y = 8;
    localparam int fruit_start_x = 12;
    localparam int fruit_start_y = 8;

    // tilt magnitude below this is ignored
    localparam int deadzone = 2;

    // fruit LFSR seeds
    localparam logic [7:0] lfsr_seed_reset = 8'hA5;
    localparam logic [7:0] lfsr_seed_restart = 8'h5A;
    localparam logic [7:0] lfsr_lockup_fill = 8'h1D;  // replaces the all-zero state

    typedef logic [15:0] bcd_score_t;  // four BCD digits
    localparam bcd_score_t score_max = 16'h9999;

    typedef enum logic [1:0] {
        dir_up    = 2'd0,
        dir_right = 2'd1,
        dir_down  = 2'd2,
        dir_left  = 2'd3
    } dir_t;

    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
    } cell_t;

    typedef struct packed {
        cell_t      head;
        logic [8:0] length;
        logic       game_over;
    } snake_view_t;

endpackage

// File: video_pkg.sv
package video_pkg;

    // first visible pixel of the 640x480 area
    localparam int h_visible_start = 144;
    localparam int v_visible_start = 35;

    // pixels per grid cell
    localparam int cell_w = 40;
    localparam int cell_h = 30;

    // 4:4:4 colours
    localparam logic [11:0] color_black = 12'h000;
    localparam logic [11:0] color_background = 12'h118;
    localparam logic [11:0] color_grid = 12'h333;
    localparam logic [11:0] color_head = 12'h0F0;
    localparam logic [11:0] color_body = 12'h0C8;
    localparam logic [11:0] color_fruit = 12'hF00;
    localparam logic [11:0] color_game_over = 12'hF44;

    // accelerometer word, steering view
    typedef struct packed {
        logic signed [4:0] tilt_v;
        logic signed [4:0] tilt_h;
        logic [4:0]        z;
    } acl_axes_t;

    // same word, low byte seeds the fruit LFSR
    typedef struct packed {
        logic [6:0] filler;
        logic [7:0] seed;
    } acl_seed_t;

    typedef union packed {
        acl_axes_t axes;
        acl_seed_t raw;
    } acl_word_u;

endpackage

// File: tilt_steer.sv
`timescale 1ns/100ps

module tilt_steer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 button,
    input  video_pkg::acl_word_u acl,
    input  game_pkg::dir_t       dir_current,
    output logic                 restart,       // one-cycle pulse
    output game_pkg::dir_t       dir_request
);
    import game_pkg::*;

    logic              btn_meta;
    logic              btn_sync;
    logic              btn_prev;
    logic signed [5:0] tilt_v;
    logic signed [5:0] tilt_h;
    logic [5:0]        mag_v;
    logic [5:0]        mag_h;
    logic              h_valid;
    logic              v_valid;
    logic              pick_h;
    dir_t              cand_dir;
    logic              opposite;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
            restart  <= 1'b0;
        end else begin
            btn_meta <= button;                  // async input
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            restart  <= btn_sync & ~btn_prev;    // rising edge
        end
    end

    assign tilt_v = $signed(acl.axes.tilt_v);
    assign tilt_h = $signed(acl.axes.tilt_h);
    assign mag_v  = tilt_v[5] ? 6'(-tilt_v) : 6'(tilt_v);
    assign mag_h  = tilt_h[5] ? 6'(-tilt_h) : 6'(tilt_h);

    assign h_valid = mag_h >= 6'(deadzone);
    assign v_valid = mag_v >= 6'(deadzone);
    assign pick_h  = h_valid && (mag_h >= mag_v || !v_valid);  // ties go horizontal

    // negative tilt means right / up on this board
    assign cand_dir = pick_h ? (tilt_h[5] ? dir_right : dir_left)
                             : (tilt_v[5] ? dir_up : dir_down);

    // opposite codes differ only in bit 1
    assign opposite = (cand_dir ^ dir_current) == 2'b10;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            dir_request <= dir_right;
        end else if ((h_valid || v_valid) && !opposite) begin
            dir_request <= cand_dir;
        end
    end

endmodule

// File: snake_engine.sv
`timescale 1ns/100ps

module snake_engine #(
    parameter int step_interval = 50_000_000
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     restart,
    input  game_pkg::dir_t                           dir_request,
    input  game_pkg::cell_t                          candidate,     // fruit candidate
    input  game_pkg::cell_t                          fruit,
    input  logic                                     fruit_pending,
    output game_pkg::dir_t                           dir_current,
    output game_pkg::cell_t [game_pkg::max_cells-1:0] body,         // body[0] is the head
    output game_pkg::snake_view_t                    snake_view,
    output logic                                     occupied,
    output logic                                     eaten,
    output logic                                     step_tick,
    output game_pkg::bcd_score_t                     score
);
    import game_pkg::*;

    localparam int cnt_w = (step_interval > 1) ? $clog2(step_interval) : 1;

    logic [cnt_w-1:0] step_cnt;
    logic [8:0]       snake_len;
    logic [8:0]       tail_idx;
    logic             game_over;
    cell_t            next_head;
    logic             border_hit;
    logic             self_hit;
    logic             will_grow;
    logic             move;

    function automatic bcd_score_t bcd_inc(bcd_score_t value);
        bcd_score_t result;
        logic       carry;
        result = value;
        carry  = 1'b1;
        for (int d = 0; d < 4; d++) begin
            if (carry) begin
                if (result[4*d +: 4] == 4'd9) begin
                    result[4*d +: 4] = 4'd0;
                end else begin
                    result[4*d +: 4] = result[4*d +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        return result;
    endfunction

    // step timer, restarts with the game
    always_ff @(posedge clk) begin
        if (rst || restart || step_tick) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    assign step_tick = step_cnt == cnt_w'(step_interval - 1);

    always_comb begin
        next_head  = body[0];
        border_hit = 1'b0;
        case (dir_request)
            dir_up: begin
                if (body[0].y == 4'd0) border_hit = 1'b1;
                else next_head.y = body[0].y - 4'd1;
            end
            dir_down: begin
                if (body[0].y == 4'(grid_h - 1)) border_hit = 1'b1;
                else next_head.y = body[0].y + 4'd1;
            end
            dir_left: begin
                if (body[0].x == 4'd0) border_hit = 1'b1;
                else next_head.x = body[0].x - 4'd1;
            end
            default: begin
                if (body[0].x == 4'(grid_w - 1)) border_hit = 1'b1;
                else next_head.x = body[0].x + 4'd1;
            end
        endcase
    end

    assign tail_idx  = snake_len - 9'd1;
    assign will_grow = !fruit_pending && !border_hit && next_head == fruit &&
                       snake_len < 9'(max_cells);

    // tail cell frees up unless the snake grows
    always_comb begin
        self_hit = 1'b0;
        occupied = 1'b0;
        for (int i = 0; i < max_cells; i++) begin
            if (9'(i) < snake_len) begin
                if (body[i] == next_head && (will_grow || 9'(i) != tail_idx)) self_hit = 1'b1;
                if (body[i] == candidate) occupied = 1'b1;
            end
        end
    end

    assign move = step_tick && !game_over && !border_hit && !self_hit;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            for (int i = 0; i < start_len; i++) begin
                body[i] <= cell_t'{x: 4'(start_x - i), y: 4'(start_y)};
            end
        end else if (move) begin
            body[0] <= next_head;
            for (int i = 1; i < max_cells; i++) begin
                body[i] <= body[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            snake_len   <= 9'(start_len);
            dir_current <= dir_right;
            game_over   <= 1'b0;
            eaten       <= 1'b0;
            score       <= '0;
        end else begin
            eaten <= 1'b0;
            if (step_tick && !game_over && (border_hit || self_hit)) begin
                game_over <= 1'b1;
            end else if (move) begin
                dir_current <= dir_request;
                if (will_grow) begin
                    snake_len <= snake_len + 9'd1;
                    eaten     <= 1'b1;
                    if (score != score_max) score <= bcd_inc(score);
                end
            end
        end
    end

    assign snake_view = snake_view_t'{head: body[0], length: snake_len, game_over: game_over};

    a_len_range: assert property (@(posedge clk) disable iff (rst)
        snake_len >= 9'(start_len) && snake_len <= 9'(max_cells));

    a_score_bcd: assert property (@(posedge clk) disable iff (rst)
        score[3:0] <= 4'd9 && score[7:4] <= 4'd9 &&
        score[11:8] <= 4'd9 && score[15:12] <= 4'd9);

    // frozen once dead, until a restart
    a_dead_still: assert property (@(posedge clk) disable iff (rst)
        game_over && !restart |=> $stable(body[0]));

endmodule

// File: fruit_placer.sv
`timescale 1ns/100ps

module fruit_placer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 restart,
    input  video_pkg::acl_word_u acl,
    input  logic                 step_tick,
    input  logic                 step_tick_seen,   // eaten pulse from the engine
    input  logic                 game_over,
    input  logic                 occupied,         // candidate lies on the snake
    output game_pkg::cell_t      fruit,
    output logic                 fruit_pending,
    output game_pkg::cell_t      candidate
);
    import game_pkg::*;

    logic [7:0] lfsr;

    function automatic logic [7:0] lfsr_next(logic [7:0] state);
        logic [7:0] nxt;
        nxt = {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
        if (nxt == 8'h00) nxt = lfsr_lockup_fill;
        return nxt;
    endfunction

    assign candidate = cell_t'{x: lfsr[3:0], y: lfsr[7:4]};

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr          <= (acl.raw.seed != 8'h00) ? acl.raw.seed : lfsr_seed_reset;
            fruit         <= cell_t'{x: 4'(fruit_start_x), y: 4'(fruit_start_y)};
            fruit_pending <= 1'b0;
        end else if (restart) begin
            lfsr          <= lfsr_next((acl.raw.seed != 8'h00) ? acl.raw.seed
                                                               : lfsr_seed_restart);
            fruit_pending <= 1'b1;
        end else begin
            if (step_tick_seen) fruit_pending <= 1'b1;
            if (fruit_pending && !game_over) begin
                if (!occupied) begin
                    fruit         <= candidate;
                    fruit_pending <= 1'b0;
                end
                lfsr <= lfsr_next(lfsr);      // redraw every clock
            end else if (step_tick && !game_over) begin
                lfsr <= lfsr_next(lfsr);
            end
        end
    end

    a_lfsr_live: assert property (@(posedge clk) disable iff (rst) lfsr != 8'h00);

endmodule

// File: pixel_render.sv
`timescale 1ns/100ps

module pixel_render (
    input  logic                                     bright,
    input  logic [9:0]                               h_count,
    input  logic [9:0]                               v_count,
    input  game_pkg::cell_t [game_pkg::max_cells-1:0] body,
    input  game_pkg::snake_view_t                    snake_view,
    input  game_pkg::cell_t                          fruit,
    input  logic                                     fruit_pending,
    output logic [11:0]                              rgb
);
    import game_pkg::*;
    import video_pkg::*;

    logic [9:0] active_x;
    logic [9:0] active_y;
    logic       within_grid;
    cell_t      pix_cell;
    logic       grid_line;
    logic       snake_hit;
    logic       head_hit;
    logic       fruit_hit;

    // left of / above the visible area wraps to a large value
    assign active_x = h_count - 10'(h_visible_start);
    assign active_y = v_count - 10'(v_visible_start);

    assign within_grid = active_x < 10'(grid_w * cell_w) &&
                         active_y < 10'(grid_h * cell_h);

    assign pix_cell.x = 4'(active_x / 10'(cell_w));
    assign pix_cell.y = 4'(active_y / 10'(cell_h));

    // cell borders plus the closing line on the far edges
    assign grid_line = (active_x % 10'(cell_w)) == 10'd0 ||
                       (active_y % 10'(cell_h)) == 10'd0 ||
                       active_x == 10'(grid_w * cell_w - 1) ||
                       active_y == 10'(grid_h * cell_h - 1);

    always_comb begin
        snake_hit = 1'b0;
        for (int i = 0; i < max_cells; i++) begin
            if (9'(i) < snake_view.length && body[i] == pix_cell) snake_hit = 1'b1;
        end
    end

    assign head_hit  = snake_view.head == pix_cell;
    assign fruit_hit = !fruit_pending && fruit == pix_cell;

    always_comb begin
        if (!bright) begin
            rgb = color_black;
        end else if (!within_grid) begin
            rgb = color_background;
        end else if (snake_hit) begin
            if (snake_view.game_over) rgb = color_game_over;
            else if (head_hit) rgb = color_head;
            else rgb = color_body;
        end else if (fruit_hit) begin
            rgb = color_fruit;
        end else if (grid_line) begin
            rgb = color_grid;
        end else begin
            rgb = color_background;
        end
    end

endmodule

// File: snake_game.sv
`timescale 1ns/100ps

module snake_game #(
    parameter int step_interval = 50_000_000   // clocks per snake step
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 bright,
    input  logic                 button,
    input  video_pkg::acl_word_u acl_data,
    input  logic [9:0]           h_count,
    input  logic [9:0]           v_count,
    output logic [11:0]          rgb,
    output game_pkg::bcd_score_t score
);
    import game_pkg::*;

    logic                  restart;
    dir_t                  dir_request;
    dir_t                  dir_current;
    cell_t [max_cells-1:0] body;
    snake_view_t           snake_view;
    logic                  occupied;
    logic                  eaten;
    logic                  step_tick;
    cell_t                 candidate;
    cell_t                 fruit;
    logic                  fruit_pending;

    tilt_steer tilt_steer_inst (
        .clk         (clk),
        .rst         (rst),
        .button      (button),
        .acl         (acl_data),
        .dir_current (dir_current),
        .restart     (restart),
        .dir_request (dir_request)
    );

    snake_engine #(
        .step_interval (step_interval)
    ) snake_engine_inst (
        .clk           (clk),
        .rst           (rst),
        .restart       (restart),
        .dir_request   (dir_request),
        .candidate     (candidate),
        .fruit         (fruit),
        .fruit_pending (fruit_pending),
        .dir_current   (dir_current),
        .body          (body),
        .snake_view    (snake_view),
        .occupied      (occupied),
        .eaten         (eaten),
        .step_tick     (step_tick),
        .score         (score)
    );

    fruit_placer fruit_placer_inst (
        .clk            (clk),
        .rst            (rst),
        .restart        (restart),
        .acl            (acl_data),
        .step_tick      (step_tick),
        .step_tick_seen (eaten),
        .game_over      (snake_view.game_over),
        .occupied       (occupied),
        .fruit          (fruit),
        .fruit_pending  (fruit_pending),
        .candidate      (candidate)
    );

    pixel_render pixel_render_inst (
        .bright        (bright),
        .h_count       (h_count),
        .v_count       (v_count),
        .body          (body),
        .snake_view    (snake_view),
        .fruit         (fruit),
        .fruit_pending (fruit_pending),
        .rgb           (rgb)
    );

endmodule

// File: tb_snake_game.sv
`timescale 1ns/100ps

module tb_snake_game;
    import video_pkg::*;

    localparam int step_interval = 64;

    logic        clk;
    logic        rst;
    logic        bright;
    logic        button;
    acl_word_u   acl_data;
    logic [9:0]  h_count;
    logic [9:0]  v_count;
    logic [11:0] rgb;
    logic [15:0] score;

    logic        rgb_check;
    logic [11:0] rgb_expect;
    logic        score_check;
    logic [15:0] score_expect;
    int          fail_count;
    int          fails_before;
    int          tests_run;

    snake_game #(
        .step_interval (step_interval)
    ) snake_game_inst (
        .clk      (clk),
        .rst      (rst),
        .bright   (bright),
        .button   (button),
        .acl_data (acl_data),
        .h_count  (h_count),
        .v_count  (v_count),
        .rgb      (rgb),
        .score    (score)
    );

    always #10 clk = ~clk;

    // next score in decimal capped at 9999
    function automatic logic [15:0] bcd_plus_one(logic [15:0] v);
        int n;
        n = v[15:12] * 1000 + v[11:8] * 100 + v[7:4] * 10 + v[3:0];
        if (n < 9999) n++;
        return {4'(n / 1000), 4'((n / 100) % 10), 4'((n / 10) % 10), 4'(n % 10)};
    endfunction

    task automatic note_fail(input string msg);
        fail_count++;
        $display("Fail at %0d ns: %s", $time, msg);
    endtask

    a_black: assert property (@(posedge clk) disable iff (rst) !bright |-> rgb == 12'h000)
        else note_fail("rgb not black while bright is low");

    a_rgb: assert property (@(posedge clk) rgb_check |-> rgb == rgb_expect)
        else note_fail($sformatf("rgb %h, expected %h", $sampled(rgb), $sampled(rgb_expect)));

    a_score: assert property (@(posedge clk) score_check |-> score == score_expect)
        else note_fail($sformatf("score %h, expected %h", $sampled(score),
                                 $sampled(score_expect)));

    a_bcd: assert property (@(posedge clk) disable iff (rst)
        score[3:0] <= 4'd9 && score[7:4] <= 4'd9 && score[11:8] <= 4'd9 && score[15:12] <= 4'd9)
        else note_fail("score digit above 9");

    // one count per eaten fruit, or back to zero on restart
    a_score_step: assert property (@(posedge clk) disable iff (rst)
        score != $past(score) |-> score == 16'h0000 || score == bcd_plus_one($past(score)))
        else note_fail("score jumped by more than one");

    // button rise -> 2 sync stages, edge reg, then the engine clears
    a_restart_hold: assert property (@(posedge clk) disable iff (rst)
        $past(button, 3) && !$past(button, 4) |-> score == $past(score))
        else note_fail("score cleared before the restart pulse");

    a_restart_clear: assert property (@(posedge clk) disable iff (rst)
        $past(button, 4) && !$past(button, 5) |-> score == 16'h0000)
        else note_fail("score not cleared 4 clocks after the button");

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic hold_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic set_tilt(input int th, input int tv);
        acl_data.axes.tilt_h = 5'(th);
        acl_data.axes.tilt_v = 5'(tv);
    endtask

    // tilt below the deadzone on both axes
    task automatic drive_noise(input int cycles);
        int nh;
        int nv;
        repeat (cycles) begin
            nh = int'($urandom_range(2)) - 1;
            nv = int'($urandom_range(2)) - 1;
            set_tilt(nh, nv);
            @(negedge clk);
        end
    endtask

    task automatic probe_pixel(input int h, input int v, input logic on, input logic [11:0] want);
        bright     = on;
        h_count    = 10'(h);
        v_count    = 10'(v);
        rgb_expect = want;
        rgb_check  = 1'b1;
        @(negedge clk);
        rgb_check = 1'b0;
        bright    = 1'b0;
    endtask

    task automatic probe_cell(input int cx, input int cy, input logic [11:0] want);
        probe_pixel(144 + 40 * cx + 20, 35 + 30 * cy + 15, 1'b1, want);
    endtask

    task automatic expect_score(input logic [15:0] want);
        score_expect = want;
        score_check  = 1'b1;
        @(negedge clk);
        score_check = 1'b0;
    endtask

    task automatic wait_score_change(input logic [15:0] old, input int limit, input string what);
        int waited;
        waited = 0;
        while (score == old && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (score == old) stop_on_timeout(what);
    endtask

    task automatic wait_cell_colour(input int cx, input int cy, input logic [11:0] colour,
                                    input int limit, input string what);
        int   waited;
        logic found;
        bright  = 1'b1;
        h_count = 10'(144 + 40 * cx + 20);
        v_count = 10'(35 + 30 * cy + 15);
        @(negedge clk);
        waited = 1;
        while (rgb != colour && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        found  = rgb == colour;
        bright = 1'b0;
        if (!found) stop_on_timeout(what);
    endtask

    // start layout with the head at (8,8) and the body trailing left
    task automatic check_start_view(input logic with_fruit);
        expect_score(16'h0000);
        probe_cell(8, 8, color_head);
        for (int x = 5; x < 8; x++) probe_cell(x, 8, color_body);
        if (with_fruit) probe_cell(12, 8, color_fruit);
        probe_cell(0, 0, color_background);    // lfsr never 0 so never fruit here
        probe_pixel(144, 50, 1'b1, color_grid);
        probe_pixel(144 + 40 * 8 + 20, 35 + 30 * 8 + 15, 1'b0, 12'h000);
    endtask

    task automatic end_test(input string name);
        int failed;
        failed = fail_count - fails_before;
        tests_run++;
        if (failed == 0) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            $display("test %0d, %s: %0d failed checks", tests_run, name, failed);
        end
        fails_before = fail_count;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        bright       = 1'b0;
        button       = 1'b0;
        acl_data     = '0;
        h_count      = '0;
        v_count      = '0;
        rgb_check    = 1'b0;
        rgb_expect   = '0;
        score_check  = 1'b0;
        score_expect = '0;
        fail_count   = 0;
        fails_before = 0;
        tests_run    = 0;
        void'($urandom(32'h70f9));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_start_view(1'b1);
        end_test("reset state");

        drive_noise(100);
        set_tilt(6, 0);                        // left is opposite to the heading
        hold_cycles(70);
        set_tilt(0, 0);
        wait_score_change(16'h0000, 8 * step_interval, "the first fruit");
        expect_score(16'h0001);
        probe_cell(12, 8, color_head);
        end_test("steering and first fruit");

        set_tilt(0, 8);                        // positive vertical is down
        wait_cell_colour(12, 15, color_game_over, 12 * step_interval, "the border hit");
        probe_cell(12, 15, color_game_over);
        probe_cell(12, 14, color_game_over);
        set_tilt(6, 0);                        // a live snake would turn left here
        score_expect = 16'h0001;               // one fruit eaten so far
        score_check  = 1'b1;
        hold_cycles(4 * step_interval);
        score_check = 1'b0;
        probe_cell(12, 15, color_game_over);
        probe_cell(11, 15, color_background);
        end_test("border death");

        set_tilt(0, 0);
        button = 1'b1;
        hold_cycles(5);
        button = 1'b0;
        wait_score_change(16'h0001, 16, "the restart");
        check_start_view(1'b0);
        end_test("restart");

        $display("%0d tests run, %0d checks failed", tests_run, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: src.f
game_pkg.sv
video_pkg.sv
tilt_steer.sv
snake_engine.sv
fruit_placer.sv
pixel_render.sv
snake_game.sv
tb_snake_game.sv

// File: run_sim.sh
#!/bin/sh
# build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_snake_game -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_snake_game)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
